// ==== include/eth_fcs_defines.svh ====
// Width and CRC constants for the 64-bit Ethernet FCS inserter.
// Included by the package and by every RTL file that sizes a vector.

`ifndef ETH_FCS_DEFINES_SVH
`define ETH_FCS_DEFINES_SVH

// stream datapath
`define ETH_DATA_W 64
`define ETH_LANES 8

// crc-32 as used by 802.3, reflected form
`define ETH_CRC_W 32
`define ETH_CRC_POLY_REV 32'hEDB88320
`define ETH_CRC_INIT 32'hFFFFFFFF

`endif

// ==== src/eth_fcs_pkg.sv ====
// Shared types for the FCS inserter.
// Modules pull these in with a wildcard import in their header.

`include "eth_fcs_defines.svh"

package eth_fcs_pkg;

    // one beat of the byte-enabled stream
    typedef struct packed {
        logic [`ETH_DATA_W-1:0] data;
        logic [`ETH_LANES-1:0]  keep;
        logic                   last;
        logic                   user;
    } axis_beat_t;

    // frame controller states
    typedef enum logic [1:0] {
        IDLE,
        PAYLOAD,
        FCS
    } fcs_state_t;

endpackage

// ==== src/eth_crc64.sv ====
// Running CRC-32 over an eight-lane byte stream.
// Presents the CRC after the valid lanes of the current beat on crc_tail
// and stores the full-beat result when update is pulsed.

`timescale 1ns/1ps
`include "eth_fcs_defines.svh"

module eth_crc64 import eth_fcs_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`ETH_DATA_W-1:0] data,
    input  logic [`ETH_LANES-1:0]  keep,
    input  logic                   clear,
    input  logic                   update,
    output logic [`ETH_CRC_W-1:0]  crc_tail
);

    logic [`ETH_CRC_W-1:0] crc_q;
    logic [`ETH_CRC_W-1:0] crc_step [0:`ETH_LANES];
    logic [3:0]            lane_cnt;

    // one byte through the reflected lfsr with lsb first
    function automatic logic [`ETH_CRC_W-1:0] crc_byte(
        input logic [`ETH_CRC_W-1:0] crc_in,
        input logic [7:0]            byte_in
    );
        logic [`ETH_CRC_W-1:0] c;
        c = crc_in ^ {{(`ETH_CRC_W-8){1'b0}}, byte_in};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ `ETH_CRC_POLY_REV;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // crc after 0..8 lanes of this beat
    always_comb begin
        crc_step[0] = crc_q;
        for (int i = 0; i < `ETH_LANES; i++) begin
            crc_step[i+1] = crc_byte(crc_step[i], data[8*i +: 8]);
        end
    end

    // keep is a contiguous low run so the top set lane gives the count
    always_comb begin
        lane_cnt = '0;
        for (int i = 0; i < `ETH_LANES; i++) begin
            if (keep[i]) begin
                lane_cnt = 4'(i + 1);
            end
        end
    end

    assign crc_tail = crc_step[lane_cnt];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc_q <= `ETH_CRC_INIT;
        end else if (update) begin
            crc_q <= crc_step[`ETH_LANES];
        end
    end

endmodule

// ==== src/eth_fcs_merge.sv ====
// Splices the inverted CRC right behind the last payload byte.
// Bytes past lane 7 spill into the low lanes of a second beat.
// Purely combinational, fed with the masked last beat.

`timescale 1ns/1ps
`include "eth_fcs_defines.svh"

module eth_fcs_merge import eth_fcs_pkg::*; (
    input  axis_beat_t            data_beat,
    input  logic [`ETH_CRC_W-1:0] crc_tail,
    output axis_beat_t            fcs_beat0,
    output axis_beat_t            fcs_beat1
);

    logic [3:0]                 lane_cnt;
    logic [2*`ETH_DATA_W-1:0]   wide_data;
    logic [2*`ETH_LANES-1:0]    wide_keep;

    always_comb begin
        lane_cnt = '0;
        for (int i = 0; i < `ETH_LANES; i++) begin
            if (data_beat.keep[i]) begin
                lane_cnt = 4'(i + 1);
            end
        end

        // treat both beats as one 16-lane word
        wide_keep = {{`ETH_LANES{1'b0}}, data_beat.keep}
                  | ({{(2*`ETH_LANES-4){1'b0}}, 4'hf} << lane_cnt);
        wide_data = {{`ETH_DATA_W{1'b0}}, data_beat.data}
                  | ({{(2*`ETH_DATA_W-`ETH_CRC_W){1'b0}}, ~crc_tail} << {lane_cnt, 3'b000});

        // unused lanes go out as zero
        for (int j = 0; j < 2*`ETH_LANES; j++) begin
            if (!wide_keep[j]) begin
                wide_data[8*j +: 8] = 8'd0;
            end
        end
    end

    always_comb begin
        fcs_beat0.data = wide_data[`ETH_DATA_W-1:0];
        fcs_beat0.keep = wide_keep[`ETH_LANES-1:0];
        fcs_beat0.last = (wide_keep[2*`ETH_LANES-1:`ETH_LANES] == '0);
        fcs_beat0.user = 1'b0;

        fcs_beat1.data = wide_data[2*`ETH_DATA_W-1:`ETH_DATA_W];
        fcs_beat1.keep = wide_keep[2*`ETH_LANES-1:`ETH_LANES];
        fcs_beat1.last = |wide_keep[2*`ETH_LANES-1:`ETH_LANES];
        fcs_beat1.user = 1'b0;
    end

endmodule

// ==== src/eth_fcs_ctrl.sv ====
// Frame controller of the FCS inserter.
// Masks input lanes, steers the CRC engine, forwards payload and the
// merged FCS beat, and holds the spill beat for one extra transfer.

`timescale 1ns/1ps
`include "eth_fcs_defines.svh"

module eth_fcs_ctrl import eth_fcs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,
    output axis_beat_t crc_beat,
    output logic       crc_clear,
    output logic       crc_update,
    input  axis_beat_t fcs_beat0,
    input  axis_beat_t fcs_beat1,
    output axis_beat_t int_beat,
    output logic       int_valid,
    input  logic       ready_early,
    input  logic       ready_int
);

    fcs_state_t state_q;
    fcs_state_t state_d;
    logic       s_ready_d;
    logic       accept;
    logic       hold_load;
    axis_beat_t held_q;

    assign accept = s_valid && s_ready;

    // zero the lanes that keep marks invalid
    always_comb begin
        crc_beat = s_beat;
        for (int i = 0; i < `ETH_LANES; i++) begin
            if (!s_beat.keep[i]) begin
                crc_beat.data[8*i +: 8] = 8'd0;
            end
        end
    end

    always_comb begin
        state_d    = state_q;
        s_ready_d  = 1'b0;
        crc_clear  = 1'b0;
        crc_update = 1'b0;
        hold_load  = 1'b0;
        int_beat      = crc_beat;
        int_beat.last = 1'b0;
        int_beat.user = 1'b0;
        int_valid     = 1'b0;

        case (state_q)
            IDLE, PAYLOAD: begin
                s_ready_d = ready_early;
                int_valid = accept;
                // hold the crc at its start value between frames
                crc_clear = (state_q == IDLE);

                if (accept) begin
                    crc_clear  = 1'b0;
                    crc_update = 1'b1;
                    state_d    = PAYLOAD;
                    if (s_beat.last) begin
                        crc_clear = 1'b1;
                        state_d   = IDLE;
                        if (s_beat.user) begin
                            // bad frame, pass the error through without fcs
                            int_beat.last = 1'b1;
                            int_beat.user = 1'b1;
                        end else begin
                            int_beat = fcs_beat0;
                            if (|fcs_beat1.keep) begin
                                hold_load = 1'b1;
                                s_ready_d = 1'b0;
                                state_d   = FCS;
                            end
                        end
                    end
                end
            end
            FCS: begin
                // spill beat with the rest of the fcs
                int_beat  = held_q;
                int_valid = 1'b1;
                if (ready_int) begin
                    s_ready_d = ready_early;
                    state_d   = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            s_ready <= 1'b0;
        end else begin
            state_q <= state_d;
            s_ready <= s_ready_d;
        end
    end

    always_ff @(posedge clk) begin
        if (hold_load) begin
            held_q <= fcs_beat1;
        end
    end

endmodule

// ==== src/axis_skid_out.sv ====
// Two-register output stage with early and registered ready.
// Upstream drives a beat whenever ready_int is high; m_ready may drop
// in any cycle and the temp register catches the beat in flight.

`timescale 1ns/1ps

module axis_skid_out import eth_fcs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t int_beat,
    input  logic       int_valid,
    output logic       ready_early,
    output logic       ready_int,
    output axis_beat_t m_beat,
    output logic       m_valid,
    input  logic       m_ready
);

    axis_beat_t out_q;
    axis_beat_t tmp_q;
    logic       out_valid_q;
    logic       out_valid_d;
    logic       tmp_valid_q;
    logic       tmp_valid_d;
    logic       int_to_out;
    logic       int_to_tmp;
    logic       tmp_to_out;

    assign m_beat  = out_q;
    assign m_valid = out_valid_q;

    // room next cycle unless temp is full or about to fill
    assign ready_early = m_ready || (!tmp_valid_q && (!out_valid_q || !int_valid));

    always_comb begin
        out_valid_d = out_valid_q;
        tmp_valid_d = tmp_valid_q;
        int_to_out  = 1'b0;
        int_to_tmp  = 1'b0;
        tmp_to_out  = 1'b0;

        if (ready_int) begin
            if (m_ready || !out_valid_q) begin
                out_valid_d = int_valid;
                int_to_out  = 1'b1;
            end else begin
                tmp_valid_d = int_valid;
                int_to_tmp  = 1'b1;
            end
        end else if (m_ready) begin
            out_valid_d = tmp_valid_q;
            tmp_valid_d = 1'b0;
            tmp_to_out  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
            tmp_valid_q <= 1'b0;
            ready_int   <= 1'b0;
        end else begin
            out_valid_q <= out_valid_d;
            tmp_valid_q <= tmp_valid_d;
            ready_int   <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            out_q <= int_beat;
        end else if (tmp_to_out) begin
            out_q <= tmp_q;
        end
        if (int_to_tmp) begin
            tmp_q <= int_beat;
        end
    end

endmodule

// ==== src/eth_fcs_insert_64.sv ====
// Ethernet FCS inserter for a 64-bit byte-enabled stream.
// Appends the CRC-32 to each good frame, one extra beat when it spills.
// Frames ending with user set pass through unchanged with no FCS.

`timescale 1ns/1ps
`include "eth_fcs_defines.svh"

module eth_fcs_insert_64 import eth_fcs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,
    output axis_beat_t m_beat,
    output logic       m_valid,
    input  logic       m_ready
);

    axis_beat_t            crc_beat;
    logic                  crc_clear;
    logic                  crc_update;
    logic [`ETH_CRC_W-1:0] crc_tail;
    axis_beat_t            fcs_beat0;
    axis_beat_t            fcs_beat1;
    axis_beat_t            int_beat;
    logic                  int_valid;
    logic                  ready_early;
    logic                  ready_int;

    eth_fcs_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .s_beat      (s_beat),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .crc_beat    (crc_beat),
        .crc_clear   (crc_clear),
        .crc_update  (crc_update),
        .fcs_beat0   (fcs_beat0),
        .fcs_beat1   (fcs_beat1),
        .int_beat    (int_beat),
        .int_valid   (int_valid),
        .ready_early (ready_early),
        .ready_int   (ready_int)
    );

    eth_crc64 u_crc (
        .clk      (clk),
        .rst      (rst),
        .data     (crc_beat.data),
        .keep     (crc_beat.keep),
        .clear    (crc_clear),
        .update   (crc_update),
        .crc_tail (crc_tail)
    );

    eth_fcs_merge u_merge (
        .data_beat (crc_beat),
        .crc_tail  (crc_tail),
        .fcs_beat0 (fcs_beat0),
        .fcs_beat1 (fcs_beat1)
    );

    axis_skid_out u_skid (
        .clk         (clk),
        .rst         (rst),
        .int_beat    (int_beat),
        .int_valid   (int_valid),
        .ready_early (ready_early),
        .ready_int   (ready_int),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready)
    );

endmodule

// ==== tests/tb_eth_fcs_insert_64.sv ====
// Testbench for the 64-bit Ethernet FCS inserter.
// Sends short, long, errored and back-pressured frames and checks the output
// byte stream against a bitwise CRC-32 model of each frame.

`timescale 1ns/1ps
`include "eth_fcs_defines.svh"

module tb_eth_fcs_insert_64 import eth_fcs_pkg::*; ();

    typedef logic [7:0] byte_q_t [$];

    localparam int CLK_NS = 10;
    // worst case two beats per short frame and six per frame up to 40 bytes
    localparam int MAX_BEATS = 8*2 + 24*6 + 8*6 + 40*6;

    logic        clk;
    logic        rst;
    axis_beat_t  s_beat;
    logic        s_valid;
    logic        s_ready;
    axis_beat_t  m_beat;
    logic        m_valid;
    logic        m_ready;

    logic [15:0] lfsr;
    logic        stall_en;
    logic        gap_en;
    logic [7:0]  exp_bytes [$];
    int          exp_len [$];
    logic        exp_user [$];
    int          sent_frames;
    int          seen_frames;
    int          cur_bytes;
    int          cur_beats;
    int          checks;
    int          errors;

    always #(CLK_NS/2) clk = ~clk;

    eth_fcs_insert_64 DUT (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // reflected crc-32 computed a bit at a time with final inversion
    function automatic logic [31:0] crc32_ref(input byte_q_t bytes);
        logic [31:0] c;
        logic        fb;
        c = 32'hFFFFFFFF;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ bytes[i][b];
                c  = {1'b0, c[31:1]} ^ (fb ? `ETH_CRC_POLY_REV : 32'h0);
            end
        end
        return ~c;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic random_payload(input int n, output byte_q_t q);
        logic [31:0] r;
        q.delete();
        for (int i = 0; i < n; i++) begin
            rand_bits(8, r);
            q.push_back(r[7:0]);
        end
    endtask

    // called and returns on a falling edge
    task automatic send_frame(input byte_q_t payload, input logic err);
        logic [31:0] crc;
        logic [31:0] r;
        logic        acc;
        int          n;
        int          pos;
        n   = payload.size();
        crc = crc32_ref(payload);
        foreach (payload[i]) exp_bytes.push_back(payload[i]);
        if (!err) begin
            for (int k = 0; k < 4; k++) exp_bytes.push_back(crc[8*k +: 8]);
        end
        exp_len.push_back(err ? n : n + 4);
        exp_user.push_back(err);
        sent_frames++;
        pos = 0;
        while (pos < n) begin
            if (gap_en) begin
                rand_bits(2, r);
                if (r[1:0] == 2'b00) begin
                    s_valid = 1'b0;
                    @(negedge clk);
                end
            end
            for (int l = 0; l < 8; l++) begin
                // junk in dead lanes for the DUT to zero
                rand_bits(8, r);
                s_beat.keep[l]         = (pos + l < n);
                s_beat.data[8*l +: 8]  = (pos + l < n) ? payload[pos + l] : r[7:0];
            end
            s_beat.last = (pos + 8 >= n);
            s_beat.user = err && (pos + 8 >= n);
            s_valid     = 1'b1;
            do begin
                acc = s_ready;
                @(negedge clk);
            end while (!acc);
            pos += 8;
        end
        s_valid = 1'b0;
    endtask

    task automatic end_test(input string name, input int err0);
        while (seen_frames < sent_frames) @(negedge clk);
        $display("test %s: %0d frames so far, %0d errors", name, sent_frames, errors - err0);
    endtask

    // m_ready drawn on the rising edge and applied on the falling edge
    initial begin
        logic [31:0] r;
        forever begin
            @(posedge clk);
            rand_bits(2, r);
            @(negedge clk);
            m_ready = !(stall_en && r[1:0] == 2'b00);
        end
    end

    always @(posedge clk) begin
        if (!rst && m_valid && m_ready) begin
            cur_beats++;
            for (int i = 0; i < 8; i++) begin
                if (m_beat.keep[i]) begin
                    checks++;
                    assert (exp_bytes.size() > 0) else begin
                        $display("output byte at %0t arrived with no frame pending", $time);
                        errors++;
                    end
                    if (exp_bytes.size() > 0) begin
                        check_val("m_beat.data", exp_bytes.pop_front(), m_beat.data[8*i +: 8]);
                    end
                    cur_bytes++;
                end else begin
                    check_val("m_beat.data", 8'h00, m_beat.data[8*i +: 8]);
                end
            end
            if (!m_beat.last) begin
                check_val("m_beat.keep", 8'hff, m_beat.keep);
                check_val("m_beat.user", 1'b0, m_beat.user);
            end else begin
                seen_frames++;
                checks++;
                assert (exp_len.size() > 0) else begin
                    $display("frame end at %0t with no frame pending", $time);
                    errors++;
                end
                if (exp_len.size() > 0) begin
                    check_val("m_beat.keep contiguous", 1'b1,
                              (m_beat.keep != 0) && ((m_beat.keep & (m_beat.keep + 8'd1)) == 0));
                    check_val("frame length", exp_len[0], cur_bytes);
                    check_val("frame beats", (exp_len[0] + 7) / 8, cur_beats);
                    check_val("m_beat.user", exp_user[0], m_beat.user);
                    void'(exp_len.pop_front());
                    void'(exp_user.pop_front());
                end
                cur_bytes = 0;
                cur_beats = 0;
            end
        end
    end

    initial begin
        #((MAX_BEATS * 4 + 200) * CLK_NS);
        $display("timeout: run stalled with %0d of %0d frames seen", seen_frames, sent_frames);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        byte_q_t     q;
        logic [31:0] r;
        int          err0;
        int          n;
        clk         = 1'b0;
        rst         = 1'b1;
        s_beat      = '0;
        s_valid     = 1'b0;
        m_ready     = 1'b1;
        lfsr        = 16'd46885;
        stall_en    = 1'b0;
        gap_en      = 1'b0;
        sent_frames = 0;
        seen_frames = 0;
        cur_bytes   = 0;
        cur_beats   = 0;
        checks      = 0;
        errors      = 0;

        // model against the standard check string "123456789"
        for (int i = 0; i < 9; i++) q.push_back(8'h31 + i);
        check_val("crc32_ref", 32'hCBF43926, crc32_ref(q));

        err0 = errors;
        repeat (5) begin
            @(posedge clk);
            @(negedge clk);
            check_val("s_ready", 1'b0, s_ready);
            check_val("m_valid", 1'b0, m_valid);
        end
        rst = 1'b0;
        @(negedge clk);
        check_val("s_ready", 1'b1, s_ready);
        check_val("m_valid", 1'b0, m_valid);
        end_test("1 reset", err0);

        err0 = errors;
        for (int len = 1; len <= 8; len++) begin
            random_payload(len, q);
            send_frame(q, 1'b0);
        end
        end_test("2 single beat", err0);

        err0 = errors;
        for (int lc = 1; lc <= 8; lc++) begin
            for (int rep = 0; rep < 3; rep++) begin
                rand_bits(2, r);
                random_payload(8 * (r[1:0] + 1) + lc, q);
                send_frame(q, 1'b0);
            end
        end
        end_test("3 multi beat", err0);

        err0 = errors;
        repeat (4) begin
            rand_bits(5, r);
            random_payload(r[4:0] + 1, q);
            send_frame(q, 1'b1);
            rand_bits(5, r);
            random_payload(r[4:0] + 1, q);
            send_frame(q, 1'b0);
        end
        end_test("4 errored frames", err0);

        err0 = errors;
        gap_en   = 1'b1;
        stall_en = 1'b1;
        repeat (40) begin
            rand_bits(6, r);
            n = r[5:0] % 40 + 1;
            random_payload(n, q);
            rand_bits(3, r);
            send_frame(q, r[2:0] == 3'b000);
        end
        end_test("5 gaps and stalls", err0);
        stall_en = 1'b0;

        // nothing more may come out
        repeat (20) @(negedge clk);
        check_val("frame count", sent_frames, seen_frames);
        check_val("bytes left", 0, exp_bytes.size());

        $display("checks %0d, errors %0d, frames %0d", checks, errors, seen_frames);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
src/eth_fcs_pkg.sv
src/eth_crc64.sv
src/eth_fcs_merge.sv
src/eth_fcs_ctrl.sv
src/axis_skid_out.sv
src/eth_fcs_insert_64.sv
tests/tb_eth_fcs_insert_64.sv
